// File: Makefile
VERILATOR ?= verilator
TOP := video_scanout_tb
FILE_LIST := video_scanout.f
OBJ_DIR := obj_dir
COMMON_FLAGS := --timing --assert
LINT_FLAGS := --lint-only $(COMMON_FLAGS)
BUILD_FLAGS := --binary $(COMMON_FLAGS) -j 0
PASS_MSG := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
    parameter int cycles = 1,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in,
    output payload_t out
);

    payload_t stages [cycles];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cycles; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < cycles; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[cycles-1];

endmodule

`default_nettype wire

// File: hdl/line_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module line_fetch (
    input  logic                     clock,
    input  logic                     reset,
    input  video_pkg::video_config_t video_cfg,
    input  video_pkg::raster_pos_t   pos,
    output video_pkg::ram_addr_t     rd_addr
);

    logic in_h_window;
    logic in_v_window;
    logic line_end;
    logic frame_end;
    logic [3:0] rep_x;
    logic [3:0] rep_y;
    video_pkg::ram_addr_t column;
    video_pkg::ram_addr_t row_base;

    assign in_h_window = pos.x >= video_cfg.h_capture_start && pos.x < video_cfg.h_capture_end;
    assign in_v_window = pos.y >= video_cfg.v_capture_start && pos.y < video_cfg.v_capture_end;
    assign line_end = pos.x == video_cfg.h_total - video_pkg::coord_t'(1);
    assign frame_end = pos.y == video_cfg.v_total - video_pkg::coord_t'(1);

    // column within the captured line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            column <= '0;
            rep_x <= '0;
        end else if (!pos.running || line_end || !in_h_window) begin
            column <= '0;
            rep_x <= '0;
        end else if (rep_x == video_cfg.pxl_rep_h - 4'd1) begin
            column <= column + video_pkg::ram_addr_t'(1);
            rep_x <= '0;
        end else begin
            rep_x <= rep_x + 4'd1;
        end
    end

    // line buffer base, stepped at end of line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            row_base <= '0;
            rep_y <= '0;
        end else if (!pos.running) begin
            row_base <= '0;
            rep_y <= '0;
        end else if (line_end) begin
            if (frame_end || !in_v_window) begin
                row_base <= '0;
                rep_y <= '0;
            end else if (rep_y == video_cfg.pxl_rep_v - 4'd1) begin
                row_base <= row_base + video_cfg.line_length;
                rep_y <= '0;
            end else begin
                rep_y <= rep_y + 4'd1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_addr <= '0;
        end else begin
            rd_addr <= (pos.running && in_h_window && in_v_window) ? row_base + column : '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/overlay_flags.sv
`timescale 1ns/100ps
`default_nettype none

module overlay_flags (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     enable_osd,
    input  video_pkg::video_config_t video_cfg,
    input  video_pkg::scanline_cfg_t scanline_cfg,
    input  video_pkg::raster_pos_t   pos,
    output video_pkg::overlay_t      flags
);

    logic in_capture;
    logic in_osd_bg;
    logic line_bit;
    video_pkg::overlay_t flags_early;

    assign in_capture = pos.running
        && pos.x >= video_cfg.h_capture_start && pos.x < video_cfg.h_capture_end
        && pos.y >= video_cfg.v_capture_start && pos.y < video_cfg.v_capture_end;

    assign in_osd_bg = enable_osd
        && pos.x >= video_cfg.osd_x_start && pos.x < video_cfg.osd_x_end
        && pos.y >= video_cfg.osd_y_start && pos.y < video_cfg.osd_y_end;

    assign line_bit = scanline_cfg.thickness ? pos.y[1] : pos.y[0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flags_early <= '0;
        end else begin
            flags_early.in_capture <= in_capture;
            flags_early.in_osd_bg <= in_osd_bg;
            flags_early.is_scanline <= scanline_cfg.active && (line_bit ^ scanline_cfg.odd_even);
        end
    end

    // line up with the RAM read data
    delay_line #(
        .cycles(video_pkg::ram_read_latency),
        .payload_t(video_pkg::overlay_t)
    ) flag_delay (
        .clock(clock),
        .reset(reset),
        .in(flags_early),
        .out(flags)
    );

endmodule

`default_nettype wire

// File: hdl/pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_mixer (
    input  logic                clock,
    input  video_pkg::rgb_t     rd_data,
    input  video_pkg::overlay_t flags,
    input  video_pkg::alpha_t   intensity,
    output video_pkg::rgb_t     video_out
);

    logic [16:0] osd_scan_product;
    video_pkg::alpha_t osd_scan_alpha;
    video_pkg::rgb_t sel_data;
    video_pkg::alpha_t sel_alpha;
    logic [15:0] red_product;
    logic [15:0] green_product;
    logic [15:0] blue_product;

    // osd alpha further dimmed on scanlines
    assign osd_scan_product = 17'(video_pkg::osd_bg_alpha) * 17'(intensity);
    assign osd_scan_alpha = osd_scan_product[16:8];

    ////////////////////////////////////////////////////////////
    // select data and gain

    always_ff @(posedge clock) begin
        if (!flags.in_capture) begin
            sel_data <= '0;
            sel_alpha <= video_pkg::alpha_t'(video_pkg::one_to_one);
        end else if (flags.in_osd_bg) begin
            sel_data <= rd_data;
            sel_alpha <= flags.is_scanline ? osd_scan_alpha
                                           : video_pkg::alpha_t'(video_pkg::osd_bg_alpha);
        end else begin
            sel_data <= rd_data;
            sel_alpha <= flags.is_scanline ? intensity
                                           : video_pkg::alpha_t'(video_pkg::one_to_one);
        end
    end

    ////////////////////////////////////////////////////////////
    // scale each channel

    // 255 * 256 still fits in 16 bits
    always_ff @(posedge clock) begin
        red_product <= 16'(sel_data.red) * 16'(sel_alpha);
        green_product <= 16'(sel_data.green) * 16'(sel_alpha);
        blue_product <= 16'(sel_data.blue) * 16'(sel_alpha);
    end

    always_ff @(posedge clock) begin
        video_out.red <= red_product[15:8];
        video_out.green <= green_product[15:8];
        video_out.blue <= blue_product[15:8];
    end

endmodule

`default_nettype wire

// File: hdl/raster_timing.sv
`timescale 1ns/100ps
`default_nettype none

module raster_timing (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  video_pkg::video_config_t video_cfg,
    output video_pkg::raster_pos_t   pos,
    output video_pkg::sync_t         sync_early
);

    logic running;
    video_pkg::coord_t x_count;
    video_pkg::coord_t y_count;
    logic line_end;
    logic frame_end;
    logic h_active;
    logic v_active;
    logic visible;

    assign line_end = x_count == video_cfg.h_total - video_pkg::coord_t'(1);
    assign frame_end = y_count == video_cfg.v_total - video_pkg::coord_t'(1);

    ////////////////////////////////////////////////////////////
    // raster counters

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            x_count <= '0;
            y_count <= '0;
        end else if (!running) begin
            // start only counts while idle
            if (start) begin
                running <= 1'b1;
                x_count <= '0;
                y_count <= '0;
            end
        end else if (line_end) begin
            x_count <= '0;
            if (frame_end) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + video_pkg::coord_t'(1);
            end
        end else begin
            x_count <= x_count + video_pkg::coord_t'(1);
        end
    end

    assign pos.running = running;
    assign pos.x = x_count;
    assign pos.y = y_count;

    ////////////////////////////////////////////////////////////
    // sync and draw area

    // subtract first so start + width cannot overflow
    assign h_active = x_count >= video_cfg.h_sync_start
        && (x_count - video_cfg.h_sync_start) < video_cfg.h_sync_width;
    assign v_active = y_count >= video_cfg.v_sync_start
        && (y_count - video_cfg.v_sync_start) < video_cfg.v_sync_width;
    assign visible = x_count < video_cfg.h_visible && y_count < video_cfg.v_visible;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_early <= '0;
        end else begin
            sync_early.hsync <= (running && h_active) ? video_cfg.h_sync_pol
                                                      : ~video_cfg.h_sync_pol;
            sync_early.vsync <= (running && v_active) ? video_cfg.v_sync_pol
                                                      : ~video_cfg.v_sync_pol;
            sync_early.draw_area <= running && visible;
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_pkg.sv
`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////
    // widths and constants

    localparam int coord_w = 12;
    localparam int addr_w = 14;

    // gains are in 256ths
    localparam int one_to_one = 256;
    localparam int osd_bg_alpha = 64;

    localparam int ram_read_latency = 2;
    localparam int scanout_latency = 6;

    ////////////////////////////////////////////////////////////
    // scalar types

    typedef logic [coord_w-1:0] coord_t;
    typedef logic [addr_w-1:0] ram_addr_t;
    typedef logic [8:0] alpha_t;

    ////////////////////////////////////////////////////////////
    // packed records

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic running;
        coord_t x;
        coord_t y;
    } raster_pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic draw_area;
    } sync_t;

    typedef struct packed {
        logic in_capture;
        logic in_osd_bg;
        logic is_scanline;
    } overlay_t;

    // thickness 0 keys on y bit 0, thickness 1 on y bit 1
    typedef struct packed {
        logic active;
        logic thickness;
        logic odd_even;
        alpha_t intensity;
    } scanline_cfg_t;

    typedef struct packed {
        coord_t h_total;
        coord_t h_visible;
        coord_t h_sync_start;
        coord_t h_sync_width;
        logic h_sync_pol;
        coord_t v_total;
        coord_t v_visible;
        coord_t v_sync_start;
        coord_t v_sync_width;
        logic v_sync_pol;
        // capture window, end exclusive
        coord_t h_capture_start;
        coord_t h_capture_end;
        coord_t v_capture_start;
        coord_t v_capture_end;
        // osd background box, end exclusive
        coord_t osd_x_start;
        coord_t osd_x_end;
        coord_t osd_y_start;
        coord_t osd_y_end;
        // 1 means every pixel or line once
        logic [3:0] pxl_rep_h;
        logic [3:0] pxl_rep_v;
        ram_addr_t line_length;
    } video_config_t;

endpackage

`default_nettype wire

// File: hdl/video_scanout.sv
`timescale 1ns/100ps
`default_nettype none

module video_scanout (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     enable_osd,
    input  video_pkg::video_config_t video_cfg,
    input  video_pkg::scanline_cfg_t scanline_cfg,
    output video_pkg::ram_addr_t     rd_addr,
    input  video_pkg::rgb_t          rd_data,
    output video_pkg::rgb_t          video_out,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     draw_area
);

    video_pkg::raster_pos_t pos;
    video_pkg::sync_t sync_early;
    video_pkg::sync_t sync_late;
    video_pkg::overlay_t flags;

    ////////////////////////////////////////////////////////////
    // raster and RAM side

    raster_timing raster_timing_inst (
        .clock(clock),
        .reset(reset),
        .start(start),
        .video_cfg(video_cfg),
        .pos(pos),
        .sync_early(sync_early)
    );

    line_fetch line_fetch_inst (
        .clock(clock),
        .reset(reset),
        .video_cfg(video_cfg),
        .pos(pos),
        .rd_addr(rd_addr)
    );

    overlay_flags overlay_flags_inst (
        .clock(clock),
        .reset(reset),
        .enable_osd(enable_osd),
        .video_cfg(video_cfg),
        .scanline_cfg(scanline_cfg),
        .pos(pos),
        .flags(flags)
    );

    ////////////////////////////////////////////////////////////
    // output side

    pixel_mixer pixel_mixer_inst (
        .clock(clock),
        .rd_data(rd_data),
        .flags(flags),
        .intensity(scanline_cfg.intensity),
        .video_out(video_out)
    );

    // sync_early is already one cycle in
    delay_line #(
        .cycles(video_pkg::scanout_latency - 1),
        .payload_t(video_pkg::sync_t)
    ) sync_delay (
        .clock(clock),
        .reset(reset),
        .in(sync_early),
        .out(sync_late)
    );

    assign hsync = sync_late.hsync;
    assign vsync = sync_late.vsync;
    assign draw_area = sync_late.draw_area;

endmodule

`default_nettype wire

// File: verif/video_scanout_assert.sv
`timescale 1ns/100ps
`default_nettype none

module raster_timing_assert (
    input logic                     clock,
    input logic                     reset,
    input logic                     start,
    input video_pkg::video_config_t video_cfg,
    input video_pkg::raster_pos_t   pos
);

    x_in_range: assert property (@(posedge clock) disable iff (reset)
        pos.running |-> pos.x < video_cfg.h_total)
        else $error("x count reached h_total");

    y_in_range: assert property (@(posedge clock) disable iff (reset)
        pos.running |-> pos.y < video_cfg.v_total)
        else $error("y count reached v_total");

    // start while running, x keeps stepping or wraps
    start_ignored: assert property (@(posedge clock) disable iff (reset)
        pos.running && start |=> pos.running
            && (pos.x == $past(pos.x) + video_pkg::coord_t'(1)
                || (pos.x == '0
                    && $past(pos.x) == video_cfg.h_total - video_pkg::coord_t'(1))))
        else $error("start while running disturbed the raster counters");

endmodule

bind raster_timing raster_timing_assert raster_timing_assert_inst (
    .clock(clock),
    .reset(reset),
    .start(start),
    .video_cfg(video_cfg),
    .pos(pos)
);

`default_nettype wire

// File: verif/video_scanout_tb.sv
`timescale 1ns/100ps
`default_nettype none

module video_scanout_tb;

    logic clock;
    logic reset;
    logic start;
    logic enable_osd;
    video_pkg::video_config_t video_cfg;
    video_pkg::scanline_cfg_t scanline_cfg;
    video_pkg::ram_addr_t rd_addr;
    video_pkg::rgb_t rd_data = '0;
    video_pkg::rgb_t video_out;
    logic hsync;
    logic vsync;
    logic draw_area;

    // reference raster, and the same position six cycles late
    video_pkg::raster_pos_t ref_pos;
    video_pkg::raster_pos_t ref_hist [video_pkg::scanout_latency];
    video_pkg::rgb_t ram_stage = '0;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    video_scanout video_scanout_inst (
        .clock(clock),
        .reset(reset),
        .start(start),
        .enable_osd(enable_osd),
        .video_cfg(video_cfg),
        .scanline_cfg(scanline_cfg),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .video_out(video_out),
        .hsync(hsync),
        .vsync(vsync),
        .draw_area(draw_area)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // frame RAM model with a two cycle read

    function automatic video_pkg::rgb_t ram_word(video_pkg::ram_addr_t addr);
        video_pkg::rgb_t word;
        word.red = addr[7:0] ^ 8'h3c;
        word.green = {addr[13:8], addr[1:0]} + 8'h51;
        word.blue = addr[10:3] ^ {addr[13:11], addr[4:0]};
        return word;
    endfunction

    always @(posedge clock) begin
        ram_stage <= ram_word(rd_addr);
        rd_data <= ram_stage;
    end

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            ref_pos <= '0;
            for (int i = 0; i < video_pkg::scanout_latency; i++) begin
                ref_hist[i] <= '0;
            end
        end else begin
            if (!ref_pos.running) begin
                if (start) begin
                    ref_pos.running <= 1'b1;
                    ref_pos.x <= '0;
                    ref_pos.y <= '0;
                end
            end else if (ref_pos.x == video_cfg.h_total - video_pkg::coord_t'(1)) begin
                ref_pos.x <= '0;
                if (ref_pos.y == video_cfg.v_total - video_pkg::coord_t'(1)) begin
                    ref_pos.y <= '0;
                end else begin
                    ref_pos.y <= ref_pos.y + video_pkg::coord_t'(1);
                end
            end else begin
                ref_pos.x <= ref_pos.x + video_pkg::coord_t'(1);
            end
            ref_hist[0] <= ref_pos;
            for (int i = 1; i < video_pkg::scanout_latency; i++) begin
                ref_hist[i] <= ref_hist[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // expected outputs

    function automatic video_pkg::rgb_t expected_pixel(video_pkg::raster_pos_t p);
        int col;
        int row;
        int alpha;
        logic scan;
        logic in_box;
        video_pkg::rgb_t word;
        video_pkg::rgb_t result;
        result = '0;
        if (p.running && p.x >= video_cfg.h_capture_start && p.x < video_cfg.h_capture_end
                && p.y >= video_cfg.v_capture_start && p.y < video_cfg.v_capture_end) begin
            col = int'(p.x - video_cfg.h_capture_start) / int'(video_cfg.pxl_rep_h);
            row = int'(p.y - video_cfg.v_capture_start) / int'(video_cfg.pxl_rep_v);
            word = ram_word(video_pkg::ram_addr_t'(row * int'(video_cfg.line_length) + col));
            scan = scanline_cfg.active
                && ((scanline_cfg.thickness ? p.y[1] : p.y[0]) != scanline_cfg.odd_even);
            in_box = enable_osd
                && p.x >= video_cfg.osd_x_start && p.x < video_cfg.osd_x_end
                && p.y >= video_cfg.osd_y_start && p.y < video_cfg.osd_y_end;
            if (in_box) begin
                alpha = scan ? video_pkg::osd_bg_alpha * int'(scanline_cfg.intensity) / 256
                             : video_pkg::osd_bg_alpha;
            end else begin
                alpha = scan ? int'(scanline_cfg.intensity) : video_pkg::one_to_one;
            end
            result.red = 8'((int'(word.red) * alpha) / 256);
            result.green = 8'((int'(word.green) * alpha) / 256);
            result.blue = 8'((int'(word.blue) * alpha) / 256);
        end
        return result;
    endfunction

    function automatic video_pkg::sync_t expected_sync(video_pkg::raster_pos_t p);
        video_pkg::sync_t s;
        logic h_on;
        logic v_on;
        h_on = p.running && int'(p.x) >= int'(video_cfg.h_sync_start)
            && int'(p.x) < int'(video_cfg.h_sync_start) + int'(video_cfg.h_sync_width);
        v_on = p.running && int'(p.y) >= int'(video_cfg.v_sync_start)
            && int'(p.y) < int'(video_cfg.v_sync_start) + int'(video_cfg.v_sync_width);
        s.hsync = h_on ? video_cfg.h_sync_pol : !video_cfg.h_sync_pol;
        s.vsync = v_on ? video_cfg.v_sync_pol : !video_cfg.v_sync_pol;
        s.draw_area = p.running && p.x < video_cfg.h_visible && p.y < video_cfg.v_visible;
        return s;
    endfunction

    function automatic int frame_cycles();
        return int'(video_cfg.h_total) * int'(video_cfg.v_total);
    endfunction

    // small raster so a frame is only 800 cycles
    function automatic video_pkg::video_config_t base_config();
        video_pkg::video_config_t cfg;
        cfg = '0;
        cfg.h_total = 12'd40;
        cfg.h_visible = 12'd32;
        cfg.h_sync_start = 12'd34;
        cfg.h_sync_width = 12'd4;
        cfg.h_sync_pol = 1'b1;
        cfg.v_total = 12'd20;
        cfg.v_visible = 12'd16;
        cfg.v_sync_start = 12'd17;
        cfg.v_sync_width = 12'd2;
        cfg.v_sync_pol = 1'b1;
        cfg.h_capture_start = 12'd4;
        cfg.h_capture_end = 12'd28;
        cfg.v_capture_start = 12'd2;
        cfg.v_capture_end = 12'd14;
        cfg.osd_x_start = 12'd10;
        cfg.osd_x_end = 12'd20;
        cfg.osd_y_start = 12'd5;
        cfg.osd_y_end = 12'd10;
        cfg.pxl_rep_h = 4'd1;
        cfg.pxl_rep_v = 4'd1;
        cfg.line_length = 14'd24;
        return cfg;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and check helpers

    task automatic restart(video_pkg::video_config_t cfg, logic osd,
                           video_pkg::scanline_cfg_t scan);
        @(posedge clock);
        reset <= 1'b1;
        start <= 1'b0;
        video_cfg <= cfg;
        enable_osd <= osd;
        scanline_cfg <= scan;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic check_value(string name, string what, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERROR %s: %s expected %h actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    function automatic logic sync_level(int which);
        case (which)
            0: return hsync;
            1: return vsync;
            default: return draw_area;
        endcase
    endfunction

    // returns the number of falling clock edges until the level is seen
    task automatic wait_level(string name, int which, logic level, int limit,
                              output int cycles);
        cycles = 0;
        while (cycles < limit) begin
            @(negedge clock);
            cycles++;
            if (sync_level(which) == level) begin
                break;
            end
        end
        assert (sync_level(which) == level) else begin
            $display("%s: output %0d never reached level %0b", name, which, level);
            test_errors++;
        end
    endtask

    task automatic measure_pulse(string name, int which, int limit, int exp_high,
                                 int exp_period);
        int skip;
        int high_len;
        int low_len;
        wait_level(name, which, 1'b0, limit, skip);
        wait_level(name, which, 1'b1, limit, skip);
        wait_level(name, which, 1'b0, limit, high_len);
        check_value(name, "high run", 32'(exp_high), 32'(high_len));
        if (exp_period > 0) begin
            wait_level(name, which, 1'b1, limit, low_len);
            check_value(name, "period", 32'(exp_period), 32'(high_len + low_len));
        end
    endtask

    // one frame from the first drawn pixel with syncs every cycle and pixels sampled
    task automatic check_frame(string name, int sample_every);
        int waited;
        video_pkg::raster_pos_t p;
        video_pkg::sync_t exp_sync;
        wait_level(name, 2, 1'b1, 4 * frame_cycles(), waited);
        for (int n = 0; n < frame_cycles(); n++) begin
            if (n > 0) begin
                @(negedge clock);
            end
            p = ref_hist[video_pkg::scanout_latency-1];
            exp_sync = expected_sync(p);
            check_value(name, "hsync", 32'(exp_sync.hsync), 32'(hsync));
            check_value(name, "vsync", 32'(exp_sync.vsync), 32'(vsync));
            check_value(name, "draw_area", 32'(exp_sync.draw_area), 32'(draw_area));
            if (($urandom % sample_every) == 0) begin
                check_value(name, "video_out", 32'(expected_pixel(p)), 32'(video_out));
            end
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
    endtask

    task automatic end_test(string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic reset_idle_test();
        video_pkg::video_config_t cfg;
        cfg = base_config();
        // capture window from the origin
        cfg.h_capture_start = '0;
        cfg.v_capture_start = '0;
        begin_test();
        restart(cfg, 1'b0, '0);
        for (int n = 0; n < 50; n++) begin
            @(negedge clock);
            check_value("reset_idle", "rd_addr", 32'(0), 32'(rd_addr));
            check_value("reset_idle", "video_out", 32'(0), 32'(video_out));
            check_value("reset_idle", "draw_area", 32'(0), 32'(draw_area));
        end
        end_test("reset_idle");
    endtask

    task automatic sync_timing_test();
        video_pkg::video_config_t cfg;
        int limit;
        cfg = base_config();
        limit = 2 * int'(cfg.h_total) * int'(cfg.v_total);
        begin_test();
        restart(cfg, 1'b0, '0);
        pulse_start();
        // a second start while running must change nothing
        pulse_start();
        for (int n = 0; n < 3; n++) begin
            measure_pulse("sync_timing hsync", 0, limit, int'(cfg.h_sync_width),
                          int'(cfg.h_total));
        end
        measure_pulse("sync_timing vsync", 1, limit,
                      int'(cfg.v_sync_width) * int'(cfg.h_total), 0);
        measure_pulse("sync_timing draw_area", 2, limit, int'(cfg.h_visible),
                      int'(cfg.h_total));
        end_test("sync_timing");
    endtask

    task automatic passthrough_test();
        begin_test();
        restart(base_config(), 1'b0, '0);
        pulse_start();
        check_frame("passthrough", 3);
        end_test("passthrough");
    endtask

    task automatic pixel_repeat_test();
        video_pkg::video_config_t cfg;
        cfg = base_config();
        cfg.pxl_rep_h = 4'd2;
        cfg.pxl_rep_v = 4'd2;
        begin_test();
        restart(cfg, 1'b0, '0);
        pulse_start();
        check_frame("pixel_repeat", 1);
        end_test("pixel_repeat");
    endtask

    task automatic osd_dim_test();
        begin_test();
        restart(base_config(), 1'b1, '0);
        pulse_start();
        check_frame("osd_dim", 2);
        end_test("osd_dim");
    endtask

    task automatic scanline_dim_test();
        video_pkg::scanline_cfg_t scan;
        scan = '0;
        scan.active = 1'b1;
        scan.odd_even = 1'b1;
        scan.intensity = 9'd160;
        begin_test();
        restart(base_config(), 1'b1, scan);
        pulse_start();
        check_frame("scanline_dim", 2);
        end_test("scanline_dim");
    endtask

    initial begin
        reset <= 1'b1;
        start <= 1'b0;
        enable_osd <= 1'b0;
        video_cfg <= base_config();
        scanline_cfg <= '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h8bfc_4e1b));
        reset_idle_test();
        sync_timing_test();
        passthrough_test();
        pixel_repeat_test();
        osd_dim_test();
        scanline_dim_test();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: video_scanout.f
hdl/video_pkg.sv
hdl/delay_line.sv
hdl/raster_timing.sv
hdl/line_fetch.sv
hdl/overlay_flags.sv
hdl/pixel_mixer.sv
hdl/video_scanout.sv
verif/video_scanout_assert.sv
verif/video_scanout_tb.sv
